//--- design/sensor_pkg.sv
package sensor_pkg;

	// Polled channels: four temperature sensors, then four light sensors
	localparam int CHANNEL_COUNT = 8;
	localparam int TEMP_CHANNELS = 4; // Channels 0..3 are temperature

	// clk cycles per quarter SCL period
	localparam int QUARTER_BIT = 4;

	typedef logic [$clog2(CHANNEL_COUNT)-1:0] chan_idx_t;
	typedef logic [6:0] i2c_addr_t;

	// First byte off the bus lands in the upper half
	typedef logic [15:0] raw_word_t;

	typedef logic signed [7:0] celsius_t; // Whole degrees
	typedef logic [15:0] lux_t;

	// Slave address per channel, in poll order
	localparam i2c_addr_t SENSOR_ADDR [CHANNEL_COUNT] = '{
		7'h48, // Solar
		7'h49, // Greenhouse
		7'h4A, // Ambient
		7'h4B, // Geothermal
		7'h44, // North
		7'h45, // East
		7'h46, // South
		7'h47  // West
	};

endpackage

//--- design/poll_sequencer.sv
`timescale 1ns/1ns

module poll_sequencer (
	input logic clk,
	input logic rst,
	input logic poll_enable,
	input logic done,
	output logic req,
	output sensor_pkg::i2c_addr_t req_addr,
	output sensor_pkg::chan_idx_t req_chan
);

	import sensor_pkg::*;

	logic credit; // Single request credit toward the bus master
	logic issue;
	chan_idx_t next_chan;

	// done hands the credit back in the same cycle, so the next poll
	// can go out right behind it
	assign issue = (credit || done) && poll_enable;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			credit <= 1'b1;
			req <= 1'b0;
			next_chan <= '0;
			req_chan <= '0;
		end
		else
		begin
			req <= issue;
			if (issue)
			begin
				credit <= 1'b0; // Spent on this request
				req_chan <= next_chan;
				next_chan <= next_chan + chan_idx_t'(1); // Wraps after west
			end
			else if (done)
			begin
				credit <= 1'b1;
			end
		end
	end

	// Address follows the registered channel, stable while req is high
	assign req_addr = SENSOR_ADDR[req_chan];

	// Master only finishes what was asked for
	assert property (@(posedge clk) disable iff (rst)
		done |-> !credit);

	// A spent credit cannot fund a second request right behind the first
	assert property (@(posedge clk) disable iff (rst)
		req |=> !req);

endmodule

//--- design/i2c_read_master.sv
`timescale 1ns/1ns

module i2c_read_master (
	input logic clk,
	input logic rst,
	input logic req,
	input sensor_pkg::i2c_addr_t req_addr,
	input sensor_pkg::chan_idx_t req_chan,
	input logic sda_in,
	output logic scl_low,
	output logic sda_low,
	output logic done,
	output logic rd_ack,
	output sensor_pkg::raw_word_t rd_data,
	output sensor_pkg::chan_idx_t rd_chan
);

	import sensor_pkg::*;

	localparam int QCNT_W = (QUARTER_BIT > 1) ? $clog2(QUARTER_BIT) : 1;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_START,
		ST_ADDR,
		ST_DATA0,
		ST_DATA1,
		ST_STOP
	} state_t;

	state_t state;
	logic [QCNT_W-1:0] qcnt;
	logic [1:0] phase; // Quarter within the current SCL slot
	logic [3:0] bit_cnt; // 0..7 data bits, 8 is the ack slot
	logic [7:0] tx; // Address byte with read bit
	logic quarter_end;
	logic slot_end;
	logic sample_pt;
	logic last_bit;

	assign quarter_end = (qcnt == QCNT_W'(QUARTER_BIT - 1));
	assign slot_end = quarter_end && (phase == 2'd3);
	assign sample_pt = quarter_end && (phase == 2'd1); // Middle of SCL high
	assign last_bit = (bit_cnt == 4'd8);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ST_IDLE;
			qcnt <= '0;
			phase <= 2'd0;
			bit_cnt <= 4'd0;
			done <= 1'b0;
			rd_ack <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (state == ST_IDLE)
			begin
				qcnt <= '0;
				phase <= 2'd0;
				if (req)
				begin
					state <= ST_START;
					rd_ack <= 1'b0;
				end
			end
			else if (quarter_end)
			begin
				qcnt <= '0;
				phase <= phase + 2'd1;
				if (sample_pt && state == ST_ADDR && last_bit)
					rd_ack <= !sda_in; // Slave pulls low to acknowledge
				if (slot_end)
				begin
					case (state)
						ST_START: state <= ST_ADDR;
						ST_ADDR, ST_DATA0, ST_DATA1:
						begin
							bit_cnt <= last_bit ? 4'd0 : bit_cnt + 4'd1;
							if (last_bit)
							begin
								case (state)
									ST_ADDR: state <= rd_ack ? ST_DATA0 : ST_STOP;
									ST_DATA0: state <= ST_DATA1;
									default: state <= ST_STOP;
								endcase
							end
						end
						ST_STOP:
						begin
							state <= ST_IDLE;
							done <= 1'b1;
						end
						default: state <= ST_IDLE;
					endcase
				end
			end
			else
			begin
				qcnt <= qcnt + 1'b1;
			end
		end
	end

	// Shift registers and captured channel
	always_ff @(posedge clk)
	begin
		if (state == ST_IDLE && req)
		begin
			tx <= {req_addr, 1'b1}; // R/W bit set for read
			rd_chan <= req_chan;
		end
		else if (slot_end && state == ST_ADDR && !last_bit)
		begin
			tx <= {tx[6:0], 1'b0};
		end
		if (sample_pt && !last_bit && (state == ST_DATA0 || state == ST_DATA1))
			rd_data <= {rd_data[14:0], sda_in}; // MSB first
	end

	// Bus drive. Data slots hold SCL low in quarters 0 and 3 and
	// change SDA at the start of quarter 0
	always_comb
	begin
		scl_low = 1'b0;
		sda_low = 1'b0;
		case (state)
			ST_START:
			begin
				scl_low = (phase == 2'd3);
				sda_low = (phase >= 2'd2); // SDA falls with SCL high
			end
			ST_ADDR:
			begin
				scl_low = (phase == 2'd0) || (phase == 2'd3);
				sda_low = !last_bit && !tx[7];
			end
			ST_DATA0:
			begin
				scl_low = (phase == 2'd0) || (phase == 2'd3);
				sda_low = last_bit; // Ack the first byte
			end
			ST_DATA1:
			begin
				scl_low = (phase == 2'd0) || (phase == 2'd3); // Nack after last byte
			end
			ST_STOP:
			begin
				scl_low = (phase == 2'd0);
				sda_low = (phase <= 2'd1); // SDA rises with SCL high
			end
			default: ;
		endcase
	end

	// Sequencer waits for done before asking again
	assert property (@(posedge clk) disable iff (rst)
		req |-> state == ST_IDLE);

endmodule

//--- design/reading_bank.sv
`timescale 1ns/1ns

module reading_bank (
	input logic clk,
	input logic rst,
	input logic done,
	input logic rd_ack,
	input sensor_pkg::raw_word_t rd_data,
	input sensor_pkg::chan_idx_t rd_chan,
	output sensor_pkg::celsius_t celsius [sensor_pkg::TEMP_CHANNELS],
	output sensor_pkg::lux_t lux [sensor_pkg::CHANNEL_COUNT - sensor_pkg::TEMP_CHANNELS]
);

	import sensor_pkg::*;

	logic [15:0] lsb_size; // Lux per mantissa step
	lux_t lux_calc;
	logic is_temp;
	logic [1:0] slot; // Position within its sensor group

	// Exponent in the top nibble, 12-bit mantissa below
	assign lsb_size = (16'd1 << rd_data[15:12]) / 16'd100;
	assign lux_calc = lsb_size * lux_t'(rd_data[11:0]); // Kept to 16 bits

	assign is_temp = (rd_chan < chan_idx_t'(TEMP_CHANNELS));
	assign slot = rd_chan[1:0];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < TEMP_CHANNELS; i++)
			begin
				celsius[i] <= '0;
			end
			for (int i = 0; i < CHANNEL_COUNT - TEMP_CHANNELS; i++)
			begin
				lux[i] <= '0;
			end
		end
		else if (done && rd_ack) // Unanswered polls keep the old value
		begin
			if (is_temp)
				celsius[slot] <= celsius_t'(rd_data[15:8]); // Low byte is fraction
			else
				lux[slot] <= lux_calc;
		end
	end

	// Channel captured by the master must be valid at completion
	assert property (@(posedge clk) disable iff (rst)
		done |-> !$isunknown(rd_chan));

endmodule

//--- design/sensor_hub_top.sv
`timescale 1ns/1ns

module sensor_hub_top (
	input logic clk,
	input logic rst,
	input logic poll_enable,
	input logic sda_in,
	output logic scl_low,
	output logic sda_low,
	output sensor_pkg::celsius_t celsius [sensor_pkg::TEMP_CHANNELS],
	output sensor_pkg::lux_t lux [sensor_pkg::CHANNEL_COUNT - sensor_pkg::TEMP_CHANNELS]
);

	import sensor_pkg::*;

	logic req;
	i2c_addr_t req_addr;
	chan_idx_t req_chan;
	logic done; // Also returns the request credit
	logic rd_ack;
	raw_word_t rd_data;
	chan_idx_t rd_chan;

	poll_sequencer seq_i (
		.clk(clk),
		.rst(rst),
		.poll_enable(poll_enable),
		.done(done),
		.req(req),
		.req_addr(req_addr),
		.req_chan(req_chan)
	);

	i2c_read_master master_i (
		.clk(clk),
		.rst(rst),
		.req(req),
		.req_addr(req_addr),
		.req_chan(req_chan),
		.sda_in(sda_in),
		.scl_low(scl_low),
		.sda_low(sda_low),
		.done(done),
		.rd_ack(rd_ack),
		.rd_data(rd_data),
		.rd_chan(rd_chan)
	);

	reading_bank bank_i (
		.clk(clk),
		.rst(rst),
		.done(done),
		.rd_ack(rd_ack),
		.rd_data(rd_data),
		.rd_chan(rd_chan),
		.celsius(celsius),
		.lux(lux)
	);

endmodule

//--- tests/i2c_sensor_model.sv
`timescale 1ns/1ns

module i2c_sensor_model (
	input logic scl,
	input logic sda,
	output logic sda_low
);

	// Slave addresses, in the hub's channel order
	logic [6:0] addr_tab [8] = '{7'h48, 7'h49, 7'h4A, 7'h4B, 7'h44, 7'h45, 7'h46, 7'h47};
	logic [15:0] words [8]; // Loaded by the testbench
	logic [7:0] present; // Bit set means the slave answers
	logic [6:0] addr_log [$]; // Every address seen after a start
	logic active;
	logic [7:0] shreg;
	logic [15:0] latched; // Reading taken when the address matched
	int bitn; // SCL rising edges since start
	int sel; // Selected entry, -1 when none

	initial
	begin
		sda_low = 1'b0;
		active = 1'b0;
		present = '0;
		bitn = 0;
		sel = -1;
		shreg = '0;
		latched = '0;
		for (int i = 0; i < 8; i++)
			words[i] = '0;
	end

	always @(negedge sda)
	begin
		if (scl)
		begin
			active = 1'b1; // Start condition
			bitn = 0;
			sel = -1;
		end
	end

	always @(posedge sda)
	begin
		if (scl)
		begin
			active = 1'b0; // Stop condition
			sda_low = 1'b0;
		end
	end

	always @(posedge scl)
	begin
		if (active)
		begin
			if (bitn < 8)
				shreg = {shreg[6:0], sda};
			bitn++;
		end
	end

	// Data changes only while SCL is low
	always @(negedge scl)
	begin
		if (active)
		begin
			sda_low = 1'b0;
			if (bitn == 8)
			begin
				addr_log.push_back(shreg[7:1]);
				for (int i = 0; i < 8; i++)
				begin
					if (addr_tab[i] == shreg[7:1] && present[i] && shreg[0])
					begin
						sel = i;
						latched = words[i];
					end
				end
				sda_low = (sel >= 0); // Address ack
			end
			else if (sel >= 0 && bitn >= 9 && bitn <= 16)
				sda_low = !latched[24 - bitn]; // Upper byte
			else if (sel >= 0 && bitn >= 18 && bitn <= 25)
				sda_low = !latched[25 - bitn]; // Lower byte
		end
	end

endmodule

//--- tests/sensor_hub_tb.sv
`timescale 1ns/1ns

module sensor_hub_tb;

	import sensor_pkg::*;

	localparam int NROWS = 5;
	localparam int TIMEOUT = 20000; // clk cycles per wait

	logic clk;
	logic rst;
	logic poll_enable;
	logic sda;
	logic scl;
	logic scl_low;
	logic sda_low;
	logic model_sda_low;
	celsius_t celsius [TEMP_CHANNELS];
	lux_t lux [CHANNEL_COUNT - TEMP_CHANNELS];
	int seed;
	int n_logged;

	raw_word_t row_words [NROWS][8];
	logic [7:0] row_mask [NROWS];
	celsius_t row_cel [NROWS][4];
	lux_t row_lux [NROWS][4];
	i2c_addr_t poll_order [8] = '{7'h48, 7'h49, 7'h4A, 7'h4B, 7'h44, 7'h45, 7'h46, 7'h47};

	// Wired-AND bus
	assign sda = !(sda_low || model_sda_low);
	assign scl = !scl_low;

	sensor_hub_top dut_i (
		.clk(clk),
		.rst(rst),
		.poll_enable(poll_enable),
		.sda_in(sda),
		.scl_low(scl_low),
		.sda_low(sda_low),
		.celsius(celsius),
		.lux(lux)
	);

	i2c_sensor_model model_i (
		.scl(scl),
		.sda(sda),
		.sda_low(model_sda_low)
	);

	always #20 clk = ~clk;

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check_celsius(input int ch, input celsius_t got, input celsius_t exp);
		if (got !== exp)
			stop_on_error($sformatf("mismatch at %0t: celsius channel %0d got %0d expected %0d",
				$time, ch, got, exp));
	endtask

	task automatic check_lux(input int ch, input lux_t got, input lux_t exp);
		if (got !== exp)
			stop_on_error($sformatf("mismatch at %0t: lux channel %0d got %0d expected %0d",
				$time, ch, got, exp));
	endtask

	task automatic check_addr(input int k, input i2c_addr_t got, input i2c_addr_t exp);
		if (got !== exp)
			stop_on_error($sformatf("mismatch at %0t: address log entry %0d got %h expected %h",
				$time, k, got, exp));
	endtask

	task automatic check_outputs(input int r);
		for (int i = 0; i < 4; i++)
		begin
			check_celsius(i, celsius[i], row_cel[r][i]);
			check_lux(i + 4, lux[i], row_lux[r][i]);
		end
	endtask

	task automatic wait_logs(input int n);
		int target;
		int cycles;
		target = model_i.addr_log.size() + n;
		cycles = 0;
		while (model_i.addr_log.size() < target)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT)
				stop_on_error("timeout waiting for the model to log sensor addresses");
		end
	endtask

	// lux = (2^exp / 100) * mantissa, truncated to 16 bits
	function automatic lux_t lux_rule(input raw_word_t w);
		logic [31:0] step;
		step = (32'd1 << w[15:12]) / 32'd100;
		return lux_t'(step * {20'd0, w[11:0]});
	endfunction

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		poll_enable = 1'b0;
		seed = 32'h8c21;
		// Rows: raw words, present mask, expected readings
		row_words[0] = '{16'h1980, 16'hE733, 16'h00FF, 16'h8001,
			16'h6FFF, 16'h7123, 16'hA100, 16'hFFFF};
		row_mask[0] = 8'hFF;
		row_cel[0] = '{8'sd25, -8'sd25, 8'sd0, -8'sd128};
		row_lux[0] = '{16'd0, 16'd291, 16'd2560, 16'd28345};
		row_words[1] = '{16'h7F00, 16'h0500, 16'hFF12, 16'h1000,
			16'hB002, 16'h800A, 16'hC001, 16'hE800};
		row_mask[1] = 8'hA5; // Channels 1, 3, 4, 6 silent
		row_cel[1] = '{8'sd127, -8'sd25, -8'sd1, -8'sd128};
		row_lux[1] = '{16'd0, 16'd20, 16'd2560, 16'd6144};
		row_words[2] = '{16'hC400, 16'h01FF, 16'h6400, 16'hF680,
			16'h0FFF, 16'h9064, 16'hD010, 16'h3ABC};
		row_mask[2] = 8'hFF;
		row_cel[2] = '{-8'sd60, 8'sd1, 8'sd100, -8'sd10};
		row_lux[2] = '{16'd0, 16'd500, 16'd1296, 16'd0};
		row_words[3] = '{16'h0A55, 16'hF0AA, 16'h3201, 16'h8100,
			16'hB7D0, 16'hC800, 16'h1FFF, 16'h4ABC};
		row_mask[3] = 8'hFF;
		row_cel[3] = '{8'sd10, -8'sd16, 8'sd50, -8'sd127};
		row_lux[3] = '{16'd40000, 16'd16384, 16'd0, 16'd0}; // Second one wraps
		// Random row, expected values from the conversion rules
		row_mask[4] = 8'($random(seed));
		for (int i = 0; i < 8; i++)
			row_words[4][i] = raw_word_t'($random(seed));
		for (int i = 0; i < 4; i++)
		begin
			row_cel[4][i] = row_mask[4][i] ? celsius_t'(row_words[4][i][15:8]) : row_cel[3][i];
			row_lux[4][i] = row_mask[4][i + 4] ? lux_rule(row_words[4][i + 4]) : row_lux[3][i];
		end

		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Idle after reset: zero outputs and a quiet bus
		for (int i = 0; i < 4; i++)
		begin
			check_celsius(i, celsius[i], 8'sd0);
			check_lux(i + 4, lux[i], 16'd0);
		end
		repeat (200)
		begin
			@(negedge clk);
			if (scl_low || sda_low || model_i.addr_log.size() != 0)
				stop_on_error("bus activity seen while polling was disabled");
		end
		poll_enable = 1'b1;

		for (int r = 0; r < NROWS; r++)
		begin
			@(negedge clk);
			model_i.present = row_mask[r];
			for (int i = 0; i < 8; i++)
				model_i.words[i] = row_words[r][i];
			wait_logs(9); // Ninth start means the eighth result is stored
			check_outputs(r);
		end

		// Stop polling, the read in flight may still finish
		@(negedge clk);
		poll_enable = 1'b0;
		n_logged = model_i.addr_log.size();
		repeat (1500) @(negedge clk);
		if (model_i.addr_log.size() > n_logged + 1)
			stop_on_error("new polls started after polling was disabled");
		check_outputs(NROWS - 1);

		for (int k = 0; k < model_i.addr_log.size(); k++)
			check_addr(k, model_i.addr_log[k], poll_order[k % 8]);

		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- sources.f
design/sensor_pkg.sv
design/poll_sequencer.sv
design/i2c_read_master.sv
design/reading_bank.sv
design/sensor_hub_top.sv
tests/i2c_sensor_model.sv
tests/sensor_hub_tb.sv

//--- Makefile
SIM := verilator
FLAGS := --binary --timing --assert -Wno-fatal
TOP := sensor_hub_tb
FILELIST := sources.f
LOG := sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)_bin
	./obj_dir/$(TOP)_bin > $(LOG) 2>&1; cat $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
